// File: rtl/ext_bus_pkg.sv
// Host word channel definitions
`default_nettype none

package ext_bus_pkg;

	// one word on the service processor channel in either direction
	typedef logic [15:0] io_word_t;

	// a data word as seen by the target side (registers and disk FIFOs)
	typedef logic [31:0] ext_word_t;

	// target address taken verbatim from the second word of a command
	typedef logic [15:0] ext_addr_t;

	// command codes are sent as the first word of every transfer
	// a write reply carries clk_rate first, then data pairs follow
	localparam io_word_t cmd_wr_c = 16'h0061;
	// a read takes a dummy word, then low/high reply pairs
	localparam io_word_t cmd_rd_c = 16'h0062;
	// a status command ends with the reply to its command word
	localparam io_word_t cmd_status_c = 16'h0063;

	// upper byte of the status reply with the request flags below it
	localparam logic [7:0] status_prefix_c = 8'h80;

	// the word counter saturates here so a very long burst never wraps
	// back into the command or address position
	localparam logic [9:0] word_cnt_max_c = 10'h3FF;

endpackage

`default_nettype wire

// File: rtl/ext_map_pkg.sv
// Target address map
`default_nettype none

package ext_map_pkg;

	// disk data ports
	// either address switches the bridge into disk mode, where the
	// address stays fixed and data goes through the disk FIFOs
	localparam logic [15:0] hdd_port_lo_c = 16'h2000;
	localparam logic [15:0] hdd_port_hi_c = 16'h2001;

	// distance between two consecutive 32-bit register words
	// the bridge adds this between data pairs in register mode
	localparam logic [15:0] addr_step_c = 16'd4;

	// first address of the configuration register window
	// register n lives at reg_base_c + n * addr_step_c
	localparam logic [15:0] reg_base_c = 16'h0000;

endpackage

`default_nettype wire

// File: rtl/ext_cmd_bridge.sv
// Host command bridge
`default_nettype none
`timescale 1ns/10ps

module ext_cmd_bridge
	import ext_bus_pkg::*, ext_map_pkg::*;
(
	input  wire             clk_sys,
	input  wire             rst_n,

	// host word channel
	input  wire             io_enable,
	input  wire             io_strobe,
	input  wire io_word_t   io_din,
	output io_word_t        io_dout,
	output logic            dout_en,

	// values reported back to the host
	input  wire ext_word_t  clk_rate,
	input  wire logic [7:0] ext_req,

	// register file side
	output ext_addr_t       reg_addr,
	output ext_word_t       reg_wr_data,
	input  wire ext_word_t  reg_rd_data,
	output logic            reg_rd,
	output logic            reg_wr,

	// disk FIFO side
	// the write word is shared with the register file
	input  wire ext_word_t  hdd_rd_data,
	output logic            hdd_wr,
	output logic            hdd_rd
);

	// saturating position of the current word inside the transfer
	logic [$bits(word_cnt_max_c)-1:0] word_cnt;
	// command code latched from word 0
	io_word_t cmd;
	// low/high toggle for 32-bit data pairs where the low half comes first
	logic hilo;
	// set when the address word named one of the disk data ports
	logic hdd_mode;
	// a register read went out last cycle and its data is on reg_rd_data now
	logic rd_pending;

	// a strobe that belongs to an open transfer
	logic stb;
	logic cmd_word;
	logic addr_word;
	logic data_word;
	// data-phase strobes of a write or a read command
	logic wr_stb;
	logic rd_stb;
	// the register address moves on this strobe
	logic addr_adv;

	assign stb       = io_enable && io_strobe;
	assign cmd_word  = (word_cnt == 0);
	assign addr_word = (word_cnt == 1);
	// words 1 and 2 carry clk_rate (write) or a dummy (read) and data starts at 3
	assign data_word = (word_cnt >= 3);

	assign wr_stb = stb && data_word && (cmd == cmd_wr_c);
	assign rd_stb = stb && data_word && (cmd == cmd_rd_c);

	// a write moves on at the low word of every pair except the first one,
	// so the first pair lands on the address the host gave
	// a read moves on after the high half has gone out
	// in disk mode the address stays on the port
	assign addr_adv = !hdd_mode && (
		(wr_stb && !hilo && word_cnt > 4) ||
		(rd_stb && hilo));

	// address and write data follow the word stream
	always_ff @(posedge clk_sys) begin
		if (stb && addr_word) begin
			reg_addr <= io_din;
		end else if (addr_adv) begin
			reg_addr <= reg_addr + addr_step_c;
		end

		// the word is assembled low half first, and the strobe that
		// delivers the high half also fires the write one cycle later
		if (wr_stb && !hilo) begin
			reg_wr_data[15:0] <= io_din;
		end
		if (wr_stb && hilo) begin
			reg_wr_data[31:16] <= io_din;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			word_cnt   <= '0;
			cmd        <= '0;
			hilo       <= 1'b0;
			hdd_mode   <= 1'b0;
			rd_pending <= 1'b0;
			dout_en    <= 1'b0;
			io_dout    <= '0;
			reg_rd     <= 1'b0;
			reg_wr     <= 1'b0;
			hdd_rd     <= 1'b0;
			hdd_wr     <= 1'b0;
		end else begin
			// all target strobes are single-cycle pulses
			reg_rd <= 1'b0;
			reg_wr <= 1'b0;
			hdd_rd <= 1'b0;
			hdd_wr <= 1'b0;

			// reg_rd went out last cycle, so the register file has the
			// word ready now and its low half becomes the pending reply
			rd_pending <= reg_rd;
			if (rd_pending) begin
				io_dout <= reg_rd_data[15:0];
			end

			if (!io_enable) begin
				// the channel is idle, so the transfer is forgotten
				word_cnt   <= '0;
				cmd        <= '0;
				hilo       <= 1'b0;
				hdd_mode   <= 1'b0;
				rd_pending <= 1'b0;
				dout_en    <= 1'b0;
				io_dout    <= '0;
			end else if (io_strobe) begin
				// a reply is only valid for the strobe right after it
				io_dout <= '0;
				if (word_cnt != word_cnt_max_c) begin
					word_cnt <= word_cnt + 1'b1;
				end

				if (cmd_word) begin
					cmd     <= io_din;
					hilo    <= 1'b0;
					dout_en <= (io_din == cmd_wr_c) || (io_din == cmd_rd_c) ||
						(io_din == cmd_status_c);
					// every command word is answered with the status word
					io_dout <= {status_prefix_c, ext_req};
				end else begin
					if (addr_word) begin
						hdd_mode <= (io_din == hdd_port_lo_c) || (io_din == hdd_port_hi_c);
					end

					if (cmd == cmd_wr_c) begin
						if (addr_word) begin
							io_dout <= clk_rate[15:0];
						end else if (word_cnt == 2) begin
							io_dout <= clk_rate[31:16];
						end else begin
							// the high word completes the pair and goes to one target
							if (hilo) begin
								reg_wr <= !hdd_mode;
								hdd_wr <= hdd_mode;
							end
							hilo <= !hilo;
						end
					end else if (cmd == cmd_rd_c && data_word) begin
						if (hdd_mode) begin
							// the FIFO head is show-ahead, so it pops only once
							// both halves have left
							if (!hilo) begin
								io_dout <= hdd_rd_data[15:0];
							end else begin
								io_dout <= hdd_rd_data[31:16];
								hdd_rd  <= 1'b1;
							end
						end else begin
							// the low strobe starts the read and the low half
							// arrives through rd_pending two cycles later
							if (!hilo) begin
								reg_rd <= 1'b1;
							end else begin
								io_dout <= reg_rd_data[31:16];
							end
						end
						hilo <= !hilo;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/ext_reg_file.sv
// Configuration register file
`default_nettype none
`timescale 1ns/10ps

module ext_reg_file
	import ext_bus_pkg::*, ext_map_pkg::*;
#(
	parameter int unsigned REG_COUNT = 8
) (
	input  wire            clk_sys,
	input  wire            rst_n,
	input  wire ext_addr_t addr,
	input  wire ext_word_t wr_data,
	input  wire            rd,
	input  wire            wr,
	output ext_word_t      rd_data
);

	// the index stays one bit wide for a single-register file
	localparam int unsigned IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

	ext_word_t regs [REG_COUNT];

	// byte offset into the window and the register it points at
	ext_addr_t offset;
	logic [IDX_W-1:0] idx;
	logic in_window;

	assign offset = addr - reg_base_c;
	assign idx    = IDX_W'(offset / addr_step_c);

	// only aligned word addresses inside the window hit a register
	assign in_window = (addr >= reg_base_c) &&
		(offset % addr_step_c == 0) &&
		(offset / addr_step_c < REG_COUNT);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
			rd_data <= '0;
		end else begin
			// writes land on the cycle wr is high
			if (wr && in_window) begin
				regs[idx] <= wr_data;
			end
			// rd_data keeps the last read word until the next rd
			if (rd) begin
				rd_data <= in_window ? regs[idx] : '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/hdd_word_fifo.sv
// Disk word FIFO
`default_nettype none
`timescale 1ns/10ps

module hdd_word_fifo
	import ext_bus_pkg::*;
#(
	parameter int unsigned FIFO_DEPTH = 16
) (
	input  wire            clk_sys,
	input  wire            rst_n,
	input  wire            push,
	input  wire ext_word_t push_data,
	input  wire            pop,
	output ext_word_t      head_data,
	output logic           empty,
	output logic           full
);

	localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	// the fill count has to reach FIFO_DEPTH itself
	localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

	ext_word_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// there is no back-pressure, so these are the only guards
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (count == 0);
	assign full  = (count == CNT_W'(FIFO_DEPTH));

	// the show-ahead head word is forced to zero so an empty read is harmless
	assign head_data = empty ? '0 : mem[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap by compare, so the depth need not be a power of two
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end

			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				// with both or neither the level stays
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/ext_subsys.sv
// Extension port subsystem
`default_nettype none
`timescale 1ns/10ps

module ext_subsys
	import ext_bus_pkg::*;
#(
	parameter int unsigned REG_COUNT  = 8,
	parameter int unsigned FIFO_DEPTH = 16
) (
	input  wire             clk_sys,
	input  wire             rst_n,

	// host word channel from the service processor
	input  wire             io_enable,
	input  wire             io_strobe,
	input  wire io_word_t   io_din,
	output io_word_t        io_dout,
	output logic            dout_en,

	input  wire ext_word_t  clk_rate,
	input  wire logic [7:0] ext_req,

	// device side of the host-to-disk FIFO
	input  wire             hdd_out_pop,
	output ext_word_t       hdd_out_data,
	output logic            hdd_out_valid,

	// device side of the disk-to-host FIFO
	input  wire ext_word_t  hdd_in_data,
	input  wire             hdd_in_push,
	output logic            hdd_in_full
);

	// bridge to register file
	ext_addr_t reg_addr;
	ext_word_t reg_rd_data;
	logic reg_rd;
	logic reg_wr;

	// the bridge write word is shared by the register file and the outgoing FIFO
	ext_word_t wr_data;

	// bridge to disk FIFOs
	ext_word_t hdd_rd_data;
	logic hdd_wr;
	logic hdd_rd;
	logic h2d_empty;

	ext_cmd_bridge bridge_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.io_enable   (io_enable),
		.io_strobe   (io_strobe),
		.io_din      (io_din),
		.io_dout     (io_dout),
		.dout_en     (dout_en),
		.clk_rate    (clk_rate),
		.ext_req     (ext_req),
		.reg_addr    (reg_addr),
		.reg_wr_data (wr_data),
		.reg_rd_data (reg_rd_data),
		.reg_rd      (reg_rd),
		.reg_wr      (reg_wr),
		.hdd_rd_data (hdd_rd_data),
		.hdd_wr      (hdd_wr),
		.hdd_rd      (hdd_rd)
	);

	ext_reg_file #(
		.REG_COUNT (REG_COUNT)
	) reg_file_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.addr    (reg_addr),
		.wr_data (wr_data),
		.rd      (reg_rd),
		.wr      (reg_wr),
		.rd_data (reg_rd_data)
	);

	// a push into the full host-to-disk FIFO is simply lost
	hdd_word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) h2d_fifo_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.push      (hdd_wr),
		.push_data (wr_data),
		.pop       (hdd_out_pop),
		.head_data (hdd_out_data),
		.empty     (h2d_empty),
		.full      ()
	);

	assign hdd_out_valid = !h2d_empty;

	// the bridge sees a zero disk-to-host head when nothing is queued
	hdd_word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) d2h_fifo_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.push      (hdd_in_push),
		.push_data (hdd_in_data),
		.pop       (hdd_rd),
		.head_data (hdd_rd_data),
		.empty     (),
		.full      (hdd_in_full)
	);

endmodule

`default_nettype wire

// File: dv/ext_host_tasks.svh
// Host channel tasks and reference model
`ifndef EXT_HOST_TASKS_SVH
`define EXT_HOST_TASKS_SVH

// expected register contents and the words queued in each disk FIFO
logic [31:0] reg_model [REG_COUNT];
logic [31:0] h2d_q [$];
logic [31:0] d2h_q [$];
logic [15:0] lfsr;

// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one LFSR step for every bit of the word
task automatic rand_word(output logic [31:0] w);
	for (int i = 0; i < 32; i++) begin
		lfsr = lfsr_step(lfsr);
		w = {w[30:0], lfsr[0]};
	end
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
	assert (exp === act) else begin
		$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		errors++;
	end
endtask

// one strobe, then the reply that this strobe prepared, read 3 cycles later
task automatic send_word(input logic [15:0] w, output logic [15:0] reply);
	@(posedge clk_sys);
	io_strobe <= 1'b1;
	io_din    <= w;
	@(posedge clk_sys);
	io_strobe <= 1'b0;
	repeat (2) @(posedge clk_sys);
	@(negedge clk_sys);
	reply = io_dout;
endtask

// command, address and the third header word of a read or write
task automatic open_cmd(input logic [15:0] code, input logic [15:0] addr,
	output logic [15:0] r_addr, output logic [15:0] r_third);
	logic [15:0] r;
	@(posedge clk_sys);
	io_enable <= 1'b1;
	send_word(code, r);
	check_word("cmd status", {8'h80, ext_req}, r);
	check_word("cmd dout_en", 1, dout_en);
	send_word(addr, r_addr);
	send_word(16'h0000, r_third);
endtask

// drop io_enable and make sure the bridge has gone quiet
task automatic close_cmd();
	@(posedge clk_sys);
	io_enable <= 1'b0;
	repeat (2) @(posedge clk_sys);
	@(negedge clk_sys);
	check_word("idle dout_en", 0, dout_en);
	check_word("idle io_dout", 0, io_dout);
endtask

`endif

// File: dv/tb_ext_subsys.sv
// Extension subsystem testbench
`default_nettype none
`timescale 1ns/10ps

module tb_ext_subsys;

	localparam int REG_COUNT  = 8;
	localparam int FIFO_DEPTH = 16;
	localparam int H2D_WORDS  = 6;
	// header strobes of all commands plus two strobes per data word
	localparam int STROBE_TOTAL = 20 + 2 * (2 * REG_COUNT + H2D_WORDS + FIFO_DEPTH + 6);

	logic clk_sys;
	logic rst_n;
	logic io_enable;
	logic io_strobe;
	logic [15:0] io_din;
	logic [15:0] io_dout;
	logic dout_en;
	logic [31:0] clk_rate;
	logic [7:0] ext_req;
	logic hdd_out_pop;
	logic [31:0] hdd_out_data;
	logic hdd_out_valid;
	logic [31:0] hdd_in_data;
	logic hdd_in_push;
	logic hdd_in_full;
	int errors;

	`include "ext_host_tasks.svh"

	ext_subsys #(
		.REG_COUNT  (REG_COUNT),
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.io_enable     (io_enable),
		.io_strobe     (io_strobe),
		.io_din        (io_din),
		.io_dout       (io_dout),
		.dout_en       (dout_en),
		.clk_rate      (clk_rate),
		.ext_req       (ext_req),
		.hdd_out_pop   (hdd_out_pop),
		.hdd_out_data  (hdd_out_data),
		.hdd_out_valid (hdd_out_valid),
		.hdd_in_data   (hdd_in_data),
		.hdd_in_push   (hdd_in_push),
		.hdd_in_full   (hdd_in_full)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// the bridge clears one cycle after io_enable drops
	idle_clear_a: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!io_enable |=> (!dout_en && io_dout == 16'h0000))
		else begin
			$display("[FAIL] idle clear: expected dout_en 0 io_dout 0000, actual %0b %h",
				$sampled(dout_en), $sampled(io_dout));
			errors++;
		end

	// an empty host-to-disk FIFO shows a zero head
	empty_head_a: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!hdd_out_valid |-> hdd_out_data == 32'h0)
		else begin
			$display("[FAIL] empty head: expected 00000000, actual %h", $sampled(hdd_out_data));
			errors++;
		end

	// the disk ports select disk mode, anything else lands in the register window
	task automatic write_burst(input logic [15:0] addr, input int n);
		logic [15:0] r_lo;
		logic [15:0] r_hi;
		logic [31:0] w;
		open_cmd(16'h0061, addr, r_lo, r_hi);
		check_word("clk_rate lo", clk_rate[15:0], r_lo);
		check_word("clk_rate hi", clk_rate[31:16], r_hi);
		for (int i = 0; i < n; i++) begin
			rand_word(w);
			send_word(w[15:0], r_lo);
			send_word(w[31:16], r_hi);
			if (addr == 16'h2000 || addr == 16'h2001) begin
				if (h2d_q.size() < FIFO_DEPTH) begin
					h2d_q.push_back(w);
				end
			end else if (addr / 4 + i < REG_COUNT) begin
				reg_model[addr / 4 + i] = w;
			end
		end
		close_cmd();
	endtask

	// low half answers the low strobe, high half the high strobe
	task automatic read_burst(input string name, input logic [15:0] addr, input int n);
		logic [15:0] r_lo;
		logic [15:0] r_hi;
		logic [31:0] exp;
		open_cmd(16'h0062, addr, r_lo, r_hi);
		for (int i = 0; i < n; i++) begin
			exp = 32'h0;
			if (addr == 16'h2000 || addr == 16'h2001) begin
				if (d2h_q.size() > 0) begin
					exp = d2h_q.pop_front();
				end
			end else if (addr / 4 + i < REG_COUNT) begin
				exp = reg_model[addr / 4 + i];
			end
			send_word(16'h0000, r_lo);
			send_word(16'h0000, r_hi);
			check_word(name, exp, {r_hi, r_lo});
		end
		close_cmd();
	endtask

	// device fills the disk-to-host FIFO on consecutive cycles
	task automatic push_device(input int n);
		logic [31:0] w;
		for (int i = 0; i < n; i++) begin
			rand_word(w);
			@(posedge clk_sys);
			hdd_in_push <= 1'b1;
			hdd_in_data <= w;
			if (d2h_q.size() < FIFO_DEPTH) begin
				d2h_q.push_back(w);
			end
		end
		@(posedge clk_sys);
		hdd_in_push <= 1'b0;
	endtask

	// device side pops every queued word and compares the head
	task automatic drain_h2d();
		while (h2d_q.size() > 0) begin
			@(negedge clk_sys);
			check_word("h2d valid", 1, hdd_out_valid);
			check_word("h2d data", h2d_q.pop_front(), hdd_out_data);
			@(posedge clk_sys);
			hdd_out_pop <= 1'b1;
			@(posedge clk_sys);
			hdd_out_pop <= 1'b0;
		end
		@(negedge clk_sys);
		check_word("h2d drained", 0, hdd_out_valid);
	endtask

	initial begin
		logic [15:0] r;
		rst_n       = 1'b0;
		io_enable   = 1'b0;
		io_strobe   = 1'b0;
		io_din      = 16'h0000;
		clk_rate    = 32'h05F5_E100;
		ext_req     = 8'hA5;
		hdd_out_pop = 1'b0;
		hdd_in_data = 32'h0;
		hdd_in_push = 1'b0;
		lfsr        = 16'd9;
		errors      = 0;
		foreach (reg_model[i]) begin
			reg_model[i] = 32'h0;
		end
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		check_word("reset dout_en", 0, dout_en);
		check_word("reset io_dout", 0, io_dout);
		check_word("reset full", 0, hdd_in_full);

		// status only, then an unknown code
		@(posedge clk_sys);
		io_enable <= 1'b1;
		send_word(16'h0063, r);
		check_word("status word", {8'h80, ext_req}, r);
		check_word("status dout_en", 1, dout_en);
		close_cmd();
		@(posedge clk_sys);
		io_enable <= 1'b1;
		send_word(16'h0055, r);
		check_word("unknown dout_en", 0, dout_en);
		close_cmd();

		// register writes, a disk write burst, then the register read back
		// shows the disk burst left the registers alone
		write_burst(16'h0000, REG_COUNT);
		write_burst(16'h2000, H2D_WORDS);
		drain_h2d();
		read_burst("reg read", 16'h0000, REG_COUNT);
		read_burst("reg outside", 16'h0100, 1);

		// one extra pair reads the empty FIFO
		push_device(3);
		read_burst("disk read", 16'h2001, 4);
		push_device(FIFO_DEPTH + 2);
		@(negedge clk_sys);
		check_word("d2h full", 1, hdd_in_full);
		read_burst("disk overflow", 16'h2001, FIFO_DEPTH + 1);
		check_word("d2h not full", 0, hdd_in_full);

		$display("checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		repeat (STROBE_TOTAL * 4 + 256) @(posedge clk_sys);
		$display("timeout: the test sequence did not finish in time");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+dv
rtl/ext_bus_pkg.sv
rtl/ext_map_pkg.sv
rtl/ext_cmd_bridge.sv
rtl/ext_reg_file.sv
rtl/hdd_word_fifo.sv
rtl/ext_subsys.sv
dv/tb_ext_subsys.sv
